// ==== hdl/drone_pkg.sv ====
package drone_pkg;

    // ----------------------------------------
    // Sizes of the course
    // ----------------------------------------

    // Lane 0 is the bottom lane
    typedef logic [1:0] lane_t;
    typedef logic [3:0] column_t;
    // Bit n set means lane n blocked
    typedef logic [3:0] obstacle_row_t;
    // 0 easy, 1 medium, 2 hard
    typedef logic [1:0] difficulty_t;

    localparam lane_t   LANE_START  = 2'd2;
    localparam lane_t   LANE_TOP    = 2'd3;
    localparam column_t LAST_COLUMN = 4'd15;

    localparam difficulty_t LEVEL_EASY   = 2'd0;
    localparam difficulty_t LEVEL_MEDIUM = 2'd1;
    localparam difficulty_t LEVEL_HARD   = 2'd2;

    // ----------------------------------------
    // Turn periods in clock cycles
    // ----------------------------------------
    localparam int TURN_PERIOD_EASY   = 2000;
    localparam int TURN_PERIOD_MEDIUM = 1000;
    localparam int TURN_PERIOD_HARD   = 10;
    // Wide enough for the easy period
    localparam int TURN_COUNT_WIDTH   = 11;

    // Obstacle map, one binary row per column
    localparam string MAP_FILE = "hdl/course_map.mem";

    // ----------------------------------------
    // Controller states and buses
    // ----------------------------------------
    typedef enum logic [3:0] {
        idle      = 4'd0,
        prepare   = 4'd1,
        menu      = 4'd2,
        wait_turn = 4'd3,
        advance   = 4'd4,
        check     = 4'd5,
        next_turn = 4'd6,
        crashed   = 4'd7,
        landed    = 4'd8
    } flight_state_e;

    // Controller to datapath
    typedef struct packed {
        logic clear_flight;
        logic count_turn;
        logic clear_turn;
        logic steer_enable;
        logic advance;
        logic pick_level;
    } flight_cmd_t;

    // Datapath to controller
    typedef struct packed {
        logic turn_over;
        logic course_end;
        logic collision;
    } flight_status_t;

endpackage

// ==== hdl/flight_control.sv ====
`timescale 1ns/1ns

module flight_control
    import drone_pkg::*;
(
    input  logic           clock,
    input  logic           zera_as,
    input  logic           start,
    input  logic           confirm,
    input  flight_status_t status,
    output flight_cmd_t    cmd,
    output logic           won,
    output logic           lost,
    output flight_state_e  phase
);

    flight_state_e state;
    flight_state_e state_next;

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Current state visible at the top
    assign phase = state;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            // Wait for the player
            idle: begin
                if (start) begin
                    state_next = menu;
                end
            end
            // Difficulty chosen here
            menu: begin
                if (confirm) begin
                    state_next = prepare;
                end
            end
            prepare: state_next = wait_turn;
            // Steering window
            wait_turn: begin
                if (status.turn_over) begin
                    state_next = advance;
                end
            end
            advance: state_next = check;
            // Row of the new column is valid here
            check: begin
                if (status.collision) begin
                    state_next = crashed;
                end else begin
                    state_next = next_turn;
                end
            end
            next_turn: begin
                if (status.course_end) begin
                    state_next = landed;
                end else begin
                    state_next = wait_turn;
                end
            end
            // Outcome held until a new flight
            crashed, landed: begin
                if (start) begin
                    state_next = prepare;
                end
            end
            default: state_next = idle;
        endcase
    end

    // ----------------------------------------
    // Moore outputs
    // ----------------------------------------
    always_comb begin
        cmd              = '0;
        cmd.clear_flight = (state == idle) || (state == prepare);
        cmd.clear_turn   = (state == idle) || (state == prepare) || (state == next_turn);
        // Timer runs only while steering is allowed
        cmd.count_turn   = (state == wait_turn);
        cmd.steer_enable = (state == wait_turn);
        cmd.advance      = (state == advance);
        cmd.pick_level   = (state == menu);
    end

    assign won  = (state == landed);
    assign lost = (state == crashed);

endmodule

// ==== hdl/pilot_input.sv ====
`timescale 1ns/1ns

module pilot_input
    import drone_pkg::*;
(
    input  logic        clock,
    input  logic        zera_as,
    // Bit 0 up, bit 1 down
    input  logic [1:0]  stick,
    input  flight_cmd_t cmd,
    output lane_t       lane,
    output difficulty_t level
);

    logic [1:0] stick_q0;
    logic [1:0] stick_q1;
    logic [1:0] rise;

    // ----------------------------------------
    // Stick edge detection
    // ----------------------------------------
    // Two stages per line
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            stick_q0 <= '0;
            stick_q1 <= '0;
        end else begin
            stick_q0 <= stick;
            stick_q1 <= stick_q0;
        end
    end

    // One-cycle pulse per rising edge
    assign rise = stick_q0 & ~stick_q1;

    // ----------------------------------------
    // Lane counter
    // ----------------------------------------
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            lane <= LANE_START;
        end else if (cmd.clear_flight) begin
            lane <= LANE_START;
        end else if (cmd.steer_enable) begin
            // Up wins over down
            if (rise[0]) begin
                // Saturate at the top lane
                if (lane != LANE_TOP) begin
                    lane <= lane + 2'd1;
                end
            end else if (rise[1]) begin
                // Saturate at the bottom lane
                if (lane != '0) begin
                    lane <= lane - 2'd1;
                end
            end
        end
    end

    // ----------------------------------------
    // Difficulty counter, modulo three
    // ----------------------------------------
    // Cleared only by reset
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            level <= LEVEL_EASY;
        end else if (cmd.pick_level) begin
            if (rise[0]) begin
                // Hard wraps to easy
                if (level == LEVEL_HARD) begin
                    level <= LEVEL_EASY;
                end else begin
                    level <= level + 2'd1;
                end
            end else if (rise[1]) begin
                // Easy wraps to hard
                if (level == LEVEL_EASY) begin
                    level <= LEVEL_HARD;
                end else begin
                    level <= level - 2'd1;
                end
            end
        end
    end

endmodule

// ==== hdl/course_tracker.sv ====
`timescale 1ns/1ns

module course_tracker
    import drone_pkg::*;
(
    input  logic        clock,
    input  logic        zera_as,
    input  flight_cmd_t cmd,
    input  lane_t       lane,
    output column_t     column,
    output logic        course_end,
    output logic        collision
);

    obstacle_row_t map_rom [16];
    column_t       rom_addr;
    obstacle_row_t row;

    // ----------------------------------------
    // Column counter
    // ----------------------------------------
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            column <= '0;
        end else if (cmd.clear_flight) begin
            column <= '0;
        end else if (cmd.advance) begin
            // Steps at the end of the advance cycle
            column <= column + 4'd1;
        end
    end

    // Last column reached
    assign course_end = (column == LAST_COLUMN);

    // ----------------------------------------
    // Course map ROM
    // ----------------------------------------
    initial begin
        $readmemb(MAP_FILE, map_rom);
    end

    // Look one column ahead
    // Registered address, so check sees the new column
    always_ff @(posedge clock) begin
        rom_addr <= column + 4'd1;
    end

    assign row = map_rom[rom_addr];

    // ----------------------------------------
    // Collision decision
    // ----------------------------------------
    // Blocked if the drone lane bit is set
    assign collision = row[lane];

endmodule

// ==== hdl/turn_timer.sv ====
`timescale 1ns/1ns

module turn_timer
    import drone_pkg::*;
(
    input  logic        clock,
    input  logic        zera_as,
    input  flight_cmd_t cmd,
    input  difficulty_t level,
    output logic        turn_over
);

    logic [TURN_COUNT_WIDTH-1:0] count;
    logic [TURN_COUNT_WIDTH-1:0] count_last;

    // ----------------------------------------
    // Period selection
    // ----------------------------------------
    always_comb begin
        case (level)
            LEVEL_EASY:   count_last = TURN_COUNT_WIDTH'(TURN_PERIOD_EASY - 1);
            LEVEL_MEDIUM: count_last = TURN_COUNT_WIDTH'(TURN_PERIOD_MEDIUM - 1);
            // Hard, and the unused code 3
            default:      count_last = TURN_COUNT_WIDTH'(TURN_PERIOD_HARD - 1);
        endcase
    end

    // ----------------------------------------
    // Wait counter
    // ----------------------------------------
    always_ff @(posedge clock or posedge zera_as) begin
        if (zera_as) begin
            count <= '0;
        end else if (cmd.clear_turn) begin
            count <= '0;
        end else if (cmd.count_turn) begin
            // Wrap at the selected period
            if (count == count_last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Last count of the turn
    assign turn_over = (count == count_last);

endmodule

// ==== hdl/drone_sim.sv ====
`timescale 1ns/1ns

module drone_sim
    import drone_pkg::*;
(
    input  logic          clock,
    input  logic          zera_as,
    input  logic          start,
    // Bit 0 up, bit 1 down
    input  logic [1:0]    stick,
    input  logic          confirm,
    output logic          won,
    output logic          lost,
    output flight_state_e phase,
    output column_t       column,
    output lane_t         lane,
    output difficulty_t   level
);

    flight_cmd_t    cmd;
    flight_status_t status;
    logic           turn_over;
    logic           course_end;
    logic           collision;

    // Status bits gathered for the controller
    assign status = '{turn_over: turn_over, course_end: course_end, collision: collision};

    // ----------------------------------------
    // Controller
    // ----------------------------------------
    flight_control u_flight_control (
        .clock   (clock),
        .zera_as (zera_as),
        .start   (start),
        .confirm (confirm),
        .status  (status),
        .cmd     (cmd),
        .won     (won),
        .lost    (lost),
        .phase   (phase)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    pilot_input u_pilot_input (
        .clock   (clock),
        .zera_as (zera_as),
        .stick   (stick),
        .cmd     (cmd),
        .lane    (lane),
        .level   (level)
    );

    course_tracker u_course_tracker (
        .clock      (clock),
        .zera_as    (zera_as),
        .cmd        (cmd),
        .lane       (lane),
        .column     (column),
        .course_end (course_end),
        .collision  (collision)
    );

    turn_timer u_turn_timer (
        .clock     (clock),
        .zera_as   (zera_as),
        .cmd       (cmd),
        .level     (level),
        .turn_over (turn_over)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic zera_as
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 10;

    // 20 ns clock
    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // Reset held for the first cycles
    initial begin
        zera_as <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        zera_as <= 1'b0;
    end

endmodule

// ==== tb/tb_drone_sim.sv ====
`timescale 1ns/1ns

module tb_drone_sim
    import drone_pkg::*;
();

    localparam int CLOCK_PERIOD_NS    = 20;
    // Reset, menu pulses and restarts
    localparam int MENU_MARGIN_CYCLES = 2000;

    // Course side of the model
    typedef struct packed {
        column_t column;
        logic    crash;
        logic    done;
        logic    win;
    } course_model_t;

    logic          clock;
    logic          zera_as;
    logic          start;
    logic [1:0]    stick;
    logic          confirm;
    logic          won;
    logic          lost;
    flight_state_e phase;
    column_t       column;
    lane_t         lane;
    difficulty_t   level;

    obstacle_row_t map_model [16];
    course_model_t course      = '0;
    flight_state_e last_phase  = idle;
    lane_t         model_lane  = LANE_START;
    difficulty_t   model_level = LEVEL_EASY;
    logic [31:0]   rng         = 32'haf5d;
    int            num_games   = 0;

    tb_clock_gen u_clock_gen (
        .clock   (clock),
        .zera_as (zera_as)
    );

    drone_sim uut (
        .clock   (clock),
        .zera_as (zera_as),
        .start   (start),
        .stick   (stick),
        .confirm (confirm),
        .won     (won),
        .lost    (lost),
        .phase   (phase),
        .column  (column),
        .lane    (lane),
        .level   (level)
    );

    // Own copy of the course map
    initial begin
        $readmemb(MAP_FILE, map_model);
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Up, down, or both at once
    function automatic logic [1:0] pick_dir(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   return 2'b01;
            32'd1:   return 2'b10;
            default: return 2'b11;
        endcase
    endfunction

    // Up first, saturating at both ends
    function automatic lane_t step_lane(input lane_t l, input logic [1:0] dir);
        if (dir[0]) begin
            return (l == 2'd3) ? l : l + 2'd1;
        end
        if (dir[1]) begin
            return (l == 2'd0) ? l : l - 2'd1;
        end
        return l;
    endfunction

    // Modulo three in both directions
    function automatic difficulty_t step_level(input difficulty_t v, input logic [1:0] dir);
        int n;
        n = int'(v);
        if (dir[0]) begin
            n = (n + 1) % 3;
        end else if (dir[1]) begin
            n = (n + 2) % 3;
        end
        return difficulty_t'(n);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Three cycles high then three low
    task automatic pulse_stick(input logic [1:0] dir);
        flight_state_e seen;
        @(posedge clock);
        stick <= dir;
        @(posedge clock);
        // Rise pulse is live in this cycle
        @(negedge clock);
        seen = phase;
        if (seen == wait_turn) begin
            model_lane = step_lane(model_lane, dir);
        end else if (seen == menu) begin
            model_level = step_level(model_level, dir);
        end
        @(posedge clock);
        @(negedge clock);
        check_value(32'(lane), 32'(model_lane), "lane after a stick pulse");
        check_value(32'(level), 32'(model_level), "level after a stick pulse");
        @(posedge clock);
        stick <= 2'b00;
        repeat (2) @(posedge clock);
    endtask

    task automatic press_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_phase(input flight_state_e target);
        @(negedge clock);
        while (phase != target) begin
            @(negedge clock);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    // ----------------------------------------
    // Column and outcome tracking
    // ----------------------------------------
    always @(negedge clock) begin : course_monitor
        obstacle_row_t row;
        flight_state_e phase_expect;
        if (!zera_as) begin
            check_value(32'(column), 32'(course.column), "column follows the advances");
            case (last_phase)
                advance: begin
                    check_value(32'(phase), 32'(check), "advance leads to check");
                end
                check: begin
                    phase_expect = course.crash ? crashed : next_turn;
                    check_value(32'(phase), 32'(phase_expect), "state after check");
                end
                next_turn: begin
                    phase_expect = (course.column == LAST_COLUMN) ? landed : wait_turn;
                    check_value(32'(phase), 32'(phase_expect), "state after next turn");
                end
                default: ;
            endcase
            // Column moves at the end of advance and clears on prepare
            if (phase == advance) begin
                course.column = course.column + 4'd1;
            end
            if (phase == idle || phase == prepare) begin
                course.column = '0;
                course.done   = 1'b0;
            end
            // Row of the new column against the model lane
            if (phase == check) begin
                row          = map_model[course.column];
                course.crash = row[model_lane];
                if (course.crash || course.column == LAST_COLUMN) begin
                    course.done = 1'b1;
                    course.win  = !course.crash;
                end
            end
            last_phase = phase;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int            games;
        int            pulses;
        logic          careful;
        logic          over;
        obstacle_row_t ahead;
        start   <= 1'b0;
        stick   <= 2'b00;
        confirm <= 1'b0;
        rng       = xorshift32(rng);
        games     = 4 + int'(rng % 32'd3);
        num_games = games;

        @(negedge zera_as);
        @(negedge clock);
        check_value(32'(won), 32'd0, "won after reset");
        check_value(32'(lost), 32'd0, "lost after reset");
        check_value(32'(phase), 32'(idle), "phase after reset");
        check_value(32'(column), 32'd0, "column after reset");
        check_value(32'(lane), 32'(LANE_START), "lane after reset");
        check_value(32'(level), 32'(LEVEL_EASY), "level after reset");
        // Idle ignores the stick
        rng = xorshift32(rng);
        pulse_stick(pick_dir(rng));

        // Difficulty menu
        press_start();
        wait_phase(menu);
        rng    = xorshift32(rng);
        pulses = 3 + int'(rng % 32'd6);
        repeat (pulses) begin
            rng = xorshift32(rng);
            pulse_stick(pick_dir(rng));
        end
        @(posedge clock);
        confirm <= 1'b1;
        @(posedge clock);
        confirm <= 1'b0;

        for (int g = 0; g < games; g++) begin
            wait_phase(wait_turn);
            check_value(32'(lane), 32'(LANE_START), "lane at flight start");
            check_value(32'(column), 32'd0, "column at flight start");
            check_value(32'(level), 32'(model_level), "level kept across flights");
            // Careful pilot dodges by the map, the other one steers at random
            rng     = xorshift32(rng);
            careful = rng[9];
            over    = 1'b0;
            while (!over) begin
                rng   = xorshift32(rng);
                ahead = map_model[column + 4'd1];
                if (careful && ahead[model_lane]) begin
                    if (model_lane != LANE_TOP && !ahead[model_lane + 2'd1]) begin
                        pulse_stick(2'b01);
                    end else begin
                        pulse_stick(2'b10);
                    end
                end else if (!careful && rng[1:0] != 2'd0) begin
                    pulse_stick(pick_dir(rng >> 8));
                end else begin
                    idle_cycles(1 + int'(rng[4:2]));
                end
                @(negedge clock);
                over = (phase == crashed) || (phase == landed);
            end
            check_value(32'(course.done), 32'd1, "game end seen by the model");
            check_value(32'(won), 32'(course.win), "won against the model");
            check_value(32'(lost), 32'(!course.win), "lost against the model");
            // Outcome state ignores the stick
            rng = xorshift32(rng);
            pulse_stick(pick_dir(rng));
            if (g < games - 1) begin
                press_start();
                model_lane = LANE_START;
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------
    initial begin : watchdog
        longint limit_ns;
        wait (num_games != 0);
        limit_ns = longint'(num_games) * 16 * longint'(TURN_PERIOD_EASY + 50)
                 * CLOCK_PERIOD_NS + longint'(MENU_MARGIN_CYCLES) * CLOCK_PERIOD_NS;
        #(limit_ns);
        $display("Watchdog expired: the games did not finish within %0d ns", limit_ns);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation timed out");
    end

endmodule

// ==== drone_sim.f ====
hdl/drone_pkg.sv
hdl/flight_control.sv
hdl/pilot_input.sv
hdl/course_tracker.sv
hdl/turn_timer.sv
hdl/drone_sim.sv
tb/tb_clock_gen.sv
tb/tb_drone_sim.sv

// ==== Makefile ====
# Verilator flow for the drone course game

VERILATOR ?= verilator
TOP       ?= tb_drone_sim
FILELIST  ?= drone_sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The map file path is relative, so the binary runs from the project root
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/course_map.mem ====
// One binary row per course column, column 0 first
// Bits run from lane 3 down to lane 0 and a set bit marks a blocked lane
0000
0000
0100
0000
1000
0000
0001
0000
0100
0010
0000
1000
0000
0001
0000
0100
